//--- include/proc_params.svh
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

////////////////////////////////////////
// Core widths
////////////////////////////////////////

// Data path width in bits
`define XLEN 16

// Architectural register count, r0 hardwired to zero
`define NUM_REGS 8

// Bits needed to name one register
`define REG_IDX_W 3

// Instruction address width
// PC counts whole 16-bit instructions, not bytes
`define PC_WIDTH 8

`endif

//--- design/proc_isa_pkg.sv
`include "proc_params.svh"

package proc_isa_pkg;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Values 9..15 are left unassigned and decode as illegal
  typedef enum logic [3:0] {
    NOP  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    ADDI = 4'h6,   // rd = rs1 + sext(imm6)
    LI   = 4'h7,   // rd = sext(imm9)
    HALT = 4'h8
  } opcode_e;

  ////////////////////////////////////////
  // Instruction layout
  ////////////////////////////////////////

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rs1;    // Bits 8:6
    logic [`REG_IDX_W-1:0] rs2;    // Bits 5:3
    logic [2:0]            spare;  // Bits 2:0, ignored
  } reg_fields_t;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rs1;
    logic [5:0]            imm6;   // ADDI immediate, signed
  } imm_fields_t;

  // Low nine bits read three ways depending on opcode
  typedef union packed {
    reg_fields_t r;
    imm_fields_t i;
    logic [8:0]  imm9;             // LI immediate, signed
  } operand_fields_t;

  typedef struct packed {
    opcode_e               opcode;  // Bits 15:12
    logic [`REG_IDX_W-1:0] rd;      // Bits 11:9
    operand_fields_t       f;
  } inst_t;

  // Sticky core status seen on the status port
  typedef enum logic [1:0] {
    NO_ERROR          = 2'h0,
    HALTED_ON_HALT    = 2'h1,
    HALTED_ON_ILLEGAL = 2'h2
  } halt_status_e;

endpackage

//--- design/proc_pipe_pkg.sv
`include "proc_params.svh"

package proc_pipe_pkg;

  import proc_isa_pkg::*;

  ////////////////////////////////////////
  // Stage boundary packets
  ////////////////////////////////////////

  // Fetch to decode, inst is the raw memory return
  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] pc;
    inst_t                inst;
  } fd_packet_t;

  // Decode to execute, operands already forwarded
  typedef struct packed {
    logic                  valid;
    logic [`PC_WIDTH-1:0]  pc;
    opcode_e               op;
    logic [`REG_IDX_W-1:0] dest;
    logic                  wr;       // Low for r0 and non-writing ops
    logic [`XLEN-1:0]      opa;
    logic [`XLEN-1:0]      opb;
    logic                  halt;
    logic                  illegal;
  } dx_packet_t;

  // Execute to commit
  typedef struct packed {
    logic                  valid;
    logic [`PC_WIDTH-1:0]  pc;
    logic [`REG_IDX_W-1:0] dest;
    logic                  wr;
    logic [`XLEN-1:0]      result;
    logic                  halt;
    logic                  illegal;
  } xc_packet_t;

  // Register write, also used as a forwarding source
  typedef struct packed {
    logic                  wr_en;
    logic [`REG_IDX_W-1:0] wr_idx;
    logic [`XLEN-1:0]      wr_data;
  } wb_packet_t;

endpackage

//--- design/fetch_stage.sv
`include "proc_params.svh"

module fetch_stage
  import proc_isa_pkg::*, proc_pipe_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 fetch_stop,  // From decode, halt or illegal seen
  input  inst_t                imem_data,   // Valid one cycle after a strobe
  output logic                 imem_rd,
  output logic [`PC_WIDTH-1:0] imem_addr,
  output fd_packet_t           fd_packet
);

  logic                 running;  // Low until the first cycle out of reset
  logic [`PC_WIDTH-1:0] pc;
  logic                 rd_q;     // Strobe delayed to meet the data
  logic [`PC_WIDTH-1:0] addr_q;   // Address delayed to meet the data

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  assign imem_rd   = running & ~fetch_stop;  // One fetch per cycle until stopped
  assign imem_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      running <= 1'b0;
      pc      <= '0;
      rd_q    <= 1'b0;
    end else begin
      running <= 1'b1;
      rd_q    <= imem_rd;
      if (imem_rd) begin
        pc <= pc + 1'b1;  // Next sequential instruction
      end
    end
  end

  // Address tag for the returning word
  always_ff @(posedge clock) begin
    addr_q <= pc;
  end

  ////////////////////////////////////////
  // Return side
  ////////////////////////////////////////

  // Memory data lands in the same cycle as the delayed strobe
  always_comb begin
    fd_packet.valid = rd_q;
    fd_packet.pc    = addr_q;
    fd_packet.inst  = imem_data;
  end

endmodule

//--- design/decode_stage.sv
`include "proc_params.svh"

module decode_stage
  import proc_isa_pkg::*, proc_pipe_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  fd_packet_t fd_packet,
  input  wb_packet_t ex_fwd,      // Result of the instruction now in execute
  input  wb_packet_t wb,          // Result now in commit, written at the edge
  output logic       fetch_stop,
  output dx_packet_t dx_packet
);

  logic [`XLEN-1:0]      rf [`NUM_REGS];
  logic                  stop_q;      // Sticky, set by HALT or illegal
  inst_t                 inst;
  logic [`REG_IDX_W-1:0] rs1;
  logic [`REG_IDX_W-1:0] rs2;
  logic [`XLEN-1:0]      imm6_sext;
  logic [`XLEN-1:0]      imm9_sext;
  logic [`XLEN-1:0]      rs1_val;
  logic [`XLEN-1:0]      rs2_val;
  logic                  writes_rd;
  logic                  is_illegal;
  logic                  live;        // Valid and not squashed
  dx_packet_t            dx_next;

  // Youngest producer wins, register file last
  function automatic logic [`XLEN-1:0] pick_operand(
    input logic [`REG_IDX_W-1:0] idx,
    input logic [`XLEN-1:0]      rf_val,
    input wb_packet_t            ex_src,
    input wb_packet_t            wb_src
  );
    if (ex_src.wr_en && ex_src.wr_idx == idx)
      return ex_src.wr_data;
    if (wb_src.wr_en && wb_src.wr_idx == idx)
      return wb_src.wr_data;
    return rf_val;
  endfunction

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (wb.wr_en) begin
      rf[wb.wr_idx] <= wb.wr_data;  // Never r0, commit clears wr_en
    end
  end

  ////////////////////////////////////////
  // Field decode and operands
  ////////////////////////////////////////

  assign inst      = fd_packet.inst;
  assign rs1       = inst.f.r.rs1;
  assign rs2       = inst.f.r.rs2;
  assign imm6_sext = {{(`XLEN-6){inst.f.i.imm6[5]}}, inst.f.i.imm6};
  assign imm9_sext = {{(`XLEN-9){inst.f.imm9[8]}}, inst.f.imm9};
  assign live      = fd_packet.valid & ~stop_q;

  // r0 reads zero, forwarding never matches it
  assign rs1_val = pick_operand(rs1, (rs1 == '0) ? '0 : rf[rs1], ex_fwd, wb);
  assign rs2_val = pick_operand(rs2, (rs2 == '0) ? '0 : rf[rs2], ex_fwd, wb);

  always_comb begin
    writes_rd  = 1'b0;
    is_illegal = 1'b0;
    case (inst.opcode)
      ADD, SUB, AND, OR, XOR, ADDI, LI: writes_rd = 1'b1;
      NOP, HALT:                        writes_rd = 1'b0;
      default:                          is_illegal = 1'b1;  // Unassigned opcode
    endcase
  end

  always_comb begin
    dx_next.valid   = live;
    dx_next.pc      = fd_packet.pc;
    dx_next.op      = inst.opcode;
    dx_next.dest    = inst.rd;
    dx_next.wr      = live & writes_rd & (inst.rd != '0);
    dx_next.halt    = live & (inst.opcode == HALT);
    dx_next.illegal = live & is_illegal;
    dx_next.opa     = (inst.opcode == LI) ? '0 : rs1_val;  // LI is 0 + imm9
    case (inst.opcode)
      ADDI:    dx_next.opb = imm6_sext;
      LI:      dx_next.opb = imm9_sext;
      default: dx_next.opb = rs2_val;
    endcase
  end

  ////////////////////////////////////////
  // Decode to execute register
  ////////////////////////////////////////

  assign fetch_stop = stop_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      stop_q            <= 1'b0;
      dx_packet.valid   <= 1'b0;
      dx_packet.wr      <= 1'b0;
      dx_packet.halt    <= 1'b0;
      dx_packet.illegal <= 1'b0;
    end else begin
      if (dx_next.halt || dx_next.illegal) begin
        stop_q <= 1'b1;  // Squash everything behind it
      end
      dx_packet <= dx_next;
    end
  end

endmodule

//--- design/exec_stage.sv
`include "proc_params.svh"

module exec_stage
  import proc_isa_pkg::*, proc_pipe_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  dx_packet_t dx_packet,
  output wb_packet_t ex_fwd,     // Back to decode in the same cycle
  output xc_packet_t xc_packet
);

  logic [`XLEN-1:0] result;
  xc_packet_t       xc_next;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (dx_packet.op)
      ADD, ADDI, LI: result = dx_packet.opa + dx_packet.opb;  // Immediates on opb
      SUB:           result = dx_packet.opa - dx_packet.opb;  // Wraps at XLEN
      AND:           result = dx_packet.opa & dx_packet.opb;
      OR:            result = dx_packet.opa | dx_packet.opb;
      XOR:           result = dx_packet.opa ^ dx_packet.opb;
      default:       result = '0;                            // NOP, HALT, illegal
    endcase
  end

  // Bubbles never forward
  always_comb begin
    ex_fwd.wr_en   = dx_packet.valid & dx_packet.wr;
    ex_fwd.wr_idx  = dx_packet.dest;
    ex_fwd.wr_data = result;
  end

  always_comb begin
    xc_next.valid   = dx_packet.valid;
    xc_next.pc      = dx_packet.pc;
    xc_next.dest    = dx_packet.dest;
    xc_next.wr      = dx_packet.valid & dx_packet.wr;
    xc_next.result  = result;
    xc_next.halt    = dx_packet.valid & dx_packet.halt;
    xc_next.illegal = dx_packet.valid & dx_packet.illegal;
  end

  ////////////////////////////////////////
  // Execute to commit register
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      xc_packet.valid   <= 1'b0;
      xc_packet.wr      <= 1'b0;
      xc_packet.halt    <= 1'b0;
      xc_packet.illegal <= 1'b0;
    end else begin
      xc_packet <= xc_next;
    end
  end

endmodule

//--- design/commit_stage.sv
`include "proc_params.svh"

module commit_stage
  import proc_isa_pkg::*, proc_pipe_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  xc_packet_t            xc_packet,
  output wb_packet_t            wb,              // To register file and forwarding
  output logic                  commit_valid,
  output logic [`PC_WIDTH-1:0]  commit_pc,
  output logic                  commit_wr_en,
  output logic [`REG_IDX_W-1:0] commit_wr_idx,
  output logic [`XLEN-1:0]      commit_wr_data,
  output halt_status_e          status
);

  ////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////

  always_comb begin
    wb.wr_en   = xc_packet.valid & xc_packet.wr;  // Halting inst writes nothing
    wb.wr_idx  = xc_packet.dest;
    wb.wr_data = xc_packet.result;
  end

  // Commit port mirrors the write-back
  assign commit_valid   = xc_packet.valid;
  assign commit_pc      = xc_packet.pc;
  assign commit_wr_en   = wb.wr_en;
  assign commit_wr_idx  = wb.wr_idx;
  assign commit_wr_data = wb.wr_data;

  ////////////////////////////////////////
  // Halt status
  ////////////////////////////////////////

  // Updates the cycle after the halting commit, then holds until reset
  always_ff @(posedge clock) begin
    if (reset) begin
      status <= NO_ERROR;
    end else if (status == NO_ERROR && xc_packet.valid) begin
      if (xc_packet.illegal) begin
        status <= HALTED_ON_ILLEGAL;  // Illegal outranks halt
      end else if (xc_packet.halt) begin
        status <= HALTED_ON_HALT;
      end
    end
  end

endmodule

//--- design/pipeline.sv
`include "proc_params.svh"

module pipeline
  import proc_isa_pkg::*, proc_pipe_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  inst_t                 imem_data,       // One cycle after imem_rd
  output logic                  imem_rd,
  output logic [`PC_WIDTH-1:0]  imem_addr,
  output logic                  commit_valid,
  output logic [`PC_WIDTH-1:0]  commit_pc,
  output logic                  commit_wr_en,
  output logic [`REG_IDX_W-1:0] commit_wr_idx,
  output logic [`XLEN-1:0]      commit_wr_data,
  output halt_status_e          status
);

  logic       fetch_stop;   // Decode back to fetch
  fd_packet_t fd_packet;
  dx_packet_t dx_packet;
  wb_packet_t ex_fwd;       // Execute result back to decode
  xc_packet_t xc_packet;
  wb_packet_t wb;           // Commit result back to decode

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////
  fetch_stage i_fetch_stage (
    // Inputs
    .clock      (clock),
    .reset      (reset),
    .fetch_stop (fetch_stop),
    .imem_data  (imem_data),
    // Outputs
    .imem_rd    (imem_rd),
    .imem_addr  (imem_addr),
    .fd_packet  (fd_packet)
  );

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  decode_stage i_decode_stage (
    .clock      (clock),
    .reset      (reset),
    .fd_packet  (fd_packet),
    .ex_fwd     (ex_fwd),
    .wb         (wb),
    .fetch_stop (fetch_stop),
    .dx_packet  (dx_packet)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  exec_stage i_exec_stage (
    .clock     (clock),
    .reset     (reset),
    .dx_packet (dx_packet),
    .ex_fwd    (ex_fwd),
    .xc_packet (xc_packet)
  );

  ////////////////////////////////////////
  // Commit
  ////////////////////////////////////////
  commit_stage i_commit_stage (
    .clock          (clock),
    .reset          (reset),
    .xc_packet      (xc_packet),
    .wb             (wb),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .status         (status)
  );

endmodule

//--- tests/pipeline_tb.sv
`include "proc_params.svh"

module pipeline_tb
  import proc_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          PROG_LEN       = 48;
  localparam int          NUM_PROGS      = 4;
  localparam int          MEM_DEPTH      = 1 << `PC_WIDTH;
  localparam int          DRAIN_CYCLES   = 8;                    // Idle cycles after the last commit
  localparam int          TIMEOUT_CYCLES = NUM_PROGS * 60 + 60;  // About 60 cycles per program
  localparam logic [31:0] LFSR_SEED      = 32'hfb57adb1;
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;         // x^32 + x^22 + x^2 + x + 1

  // One expected commit
  typedef struct packed {
    logic [`PC_WIDTH-1:0]  pc;
    logic                  wr_en;
    logic [`REG_IDX_W-1:0] idx;
    logic [`XLEN-1:0]      data;
  } commit_t;

  logic                  clock;
  logic                  reset;
  inst_t                 imem_data = '0;
  logic                  imem_rd;
  logic [`PC_WIDTH-1:0]  imem_addr;
  logic                  commit_valid;
  logic [`PC_WIDTH-1:0]  commit_pc;
  logic                  commit_wr_en;
  logic [`REG_IDX_W-1:0] commit_wr_idx;
  logic [`XLEN-1:0]      commit_wr_data;
  halt_status_e          status;

  logic [15:0]          prog [MEM_DEPTH];   // Instruction memory image
  logic                 mem_rd_q     = 1'b0;
  logic [`PC_WIDTH-1:0] mem_addr_q   = '0;
  commit_t              exp_q [$];          // Model output in program order
  halt_status_e         exp_final;          // Status after the stopping commit
  halt_status_e         exp_status;         // Status expected this cycle
  int                   strobe_at [MEM_DEPTH];
  int                   strobe_count;
  int                   local_cycle;
  int                   stop_idx;
  int                   value_errors = 0;
  int                   other_errors = 0;
  int                   cycle_count  = 0;
  logic [31:0]          lfsr_state   = LFSR_SEED;
  string                test_name;

  pipeline i_pipeline (
    .clock          (clock),
    .reset          (reset),
    .imem_data      (imem_data),
    .imem_rd        (imem_rd),
    .imem_addr      (imem_addr),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_wr_en   (commit_wr_en),
    .commit_wr_idx  (commit_wr_idx),
    .commit_wr_data (commit_wr_data),
    .status         (status)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Memory answers one cycle after the strobe, on the falling edge
  always @(negedge clock) begin
    if (mem_rd_q) imem_data <= inst_t'(prog[mem_addr_q]);
    mem_rd_q   <= imem_rd;
    mem_addr_q <= imem_addr;
  end

  ////////////////////////////////////////
  // Random numbers and programs
  ////////////////////////////////////////

  function automatic logic next_rand_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ LFSR_TAPS;  // Galois feedback
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_rand_bit()};
    return v;
  endfunction

  // Mostly r0..r3 so dependencies stay close together
  function automatic logic [2:0] pick_reg();
    if (rand_bits(2) == 0) return rand_bits(3);
    return rand_bits(2);
  endfunction

  function automatic logic [15:0] random_inst();
    logic [3:0] sel;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    logic [8:0] low;
    sel = rand_bits(4);
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    low = rand_bits(9);
    case (sel)
      0, 1, 2, 3: return {LI, rd, low};
      4, 5:       return {ADDI, rd, rs1, low[5:0]};
      6, 7, 15:   return {ADD, rd, rs1, rs2, low[2:0]};
      8, 9:       return {SUB, rd, rs1, rs2, low[2:0]};
      10:         return {AND, rd, rs1, rs2, low[2:0]};
      11:         return {OR, rd, rs1, rs2, low[2:0]};
      12, 13:     return {XOR, rd, rs1, rs2, low[2:0]};
      default:    return {NOP, rd, low};
    endcase
  endfunction

  // Unused words differ from each other
  function automatic logic [15:0] fill_word(input logic [7:0] addr);
    return {LI, addr[7:5], addr[4:0], ~addr[7:4]};
  endfunction

  task automatic build_program(input int p);
    logic [3:0] bad_op;
    for (int a = 0; a < MEM_DEPTH; a++) prog[a] = fill_word(a[7:0]);
    for (int a = 0; a < PROG_LEN; a++) prog[a] = random_inst();
    bad_op = 4'h9 + 4'(rand_bits(3) % 7);  // Somewhere in 9..15
    case (p)
      0, 2:    prog[PROG_LEN-1] = {HALT, 12'(rand_bits(12))};
      1:       prog[PROG_LEN-1] = {bad_op, 12'(rand_bits(12))};
      default: prog[PROG_LEN/2] = {HALT, 12'(rand_bits(12))};  // Dead code after it
    endcase
  endtask

  ////////////////////////////////////////
  // Reference interpreter
  ////////////////////////////////////////

  task automatic run_model();
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [15:0]      w;
    logic [`XLEN-1:0] a_val;
    logic [`XLEN-1:0] b_val;
    logic [`XLEN-1:0] val;
    logic             writes;
    logic             stopped;
    commit_t          c;
    for (int i = 0; i < `NUM_REGS; i++) regs[i] = '0;
    exp_q.delete();
    exp_final = NO_ERROR;
    stopped   = 1'b0;
    stop_idx  = -1;
    for (int a = 0; a < PROG_LEN && !stopped; a++) begin
      w      = prog[a];
      a_val  = regs[w[8:6]];  // regs[0] is never written
      b_val  = regs[w[5:3]];
      writes = 1'b1;
      val    = '0;
      case (w[15:12])
        ADD:  val = a_val + b_val;
        SUB:  val = a_val - b_val;
        AND:  val = a_val & b_val;
        OR:   val = a_val | b_val;
        XOR:  val = a_val ^ b_val;
        ADDI: val = a_val + {{(`XLEN-6){w[5]}}, w[5:0]};
        LI:   val = {{(`XLEN-9){w[8]}}, w[8:0]};
        NOP:  writes = 1'b0;
        HALT: begin
          writes    = 1'b0;
          stopped   = 1'b1;
          exp_final = HALTED_ON_HALT;
        end
        default: begin
          writes    = 1'b0;
          stopped   = 1'b1;
          exp_final = HALTED_ON_ILLEGAL;
        end
      endcase
      c.pc    = a[`PC_WIDTH-1:0];
      c.wr_en = writes && (w[11:9] != 0);  // r0 writes are dropped
      c.idx   = w[11:9];
      c.data  = val;
      if (c.wr_en) regs[c.idx] = val;
      exp_q.push_back(c);
      if (stopped) stop_idx = a;
    end
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    other_errors++;
    $display("ERROR %s", msg);
  endtask

  // One falling-edge sample of fetch, commit and status
  task automatic sample_cycle();
    commit_t c;
    if (imem_rd) begin
      if (strobe_at[imem_addr] >= 0)
        report_error($sformatf("%s: address %0d fetched twice", test_name, imem_addr));
      strobe_at[imem_addr] = local_cycle;
      strobe_count++;
    end
    check_value({test_name, " status"}, exp_status, status);
    if (commit_valid) begin
      if (exp_q.size() == 0) begin
        report_error($sformatf("%s: pc %0d committed after the stop", test_name, commit_pc));
      end else begin
        c = exp_q.pop_front();
        check_value({test_name, " commit pc"}, c.pc, commit_pc);
        check_value({test_name, " commit wr_en"}, c.wr_en, commit_wr_en);
        if (c.wr_en) begin
          check_value({test_name, " commit wr_idx"}, c.idx, commit_wr_idx);
          check_value({test_name, " commit wr_data"}, c.data, commit_wr_data);
        end
        check_value({test_name, " fetch to commit latency"}, 3,
                    local_cycle - strobe_at[commit_pc]);
        if (exp_q.size() == 0) exp_status = exp_final;  // Seen from the next cycle
      end
    end
    local_cycle++;
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset = 1'b1;
    repeat (2) @(negedge clock);
    check_value({test_name, " reset imem_rd"}, 0, imem_rd);
    check_value({test_name, " reset commit_valid"}, 0, commit_valid);
    check_value({test_name, " reset commit_wr_en"}, 0, commit_wr_en);
    check_value({test_name, " reset status"}, NO_ERROR, status);
    reset = 1'b0;
  endtask

  task automatic run_program();
    for (int a = 0; a < MEM_DEPTH; a++) strobe_at[a] = -1;
    strobe_count = 0;
    local_cycle  = 0;
    exp_status   = NO_ERROR;
    @(negedge clock);
    check_value({test_name, " first imem_rd"}, 1, imem_rd);
    check_value({test_name, " first imem_addr"}, 0, imem_addr);
    sample_cycle();
    while (exp_q.size() > 0) begin
      @(negedge clock);
      sample_cycle();
    end
    repeat (DRAIN_CYCLES) begin
      @(negedge clock);
      sample_cycle();
    end
    // Stopping instruction plus exactly one more fetch
    check_value({test_name, " fetch count"}, stop_idx + 2, strobe_count);
    check_value({test_name, " final status"}, exp_final, status);
  endtask

  ////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////

  initial begin
    reset = 1'b1;
    for (int p = 0; p < NUM_PROGS; p++) begin
      test_name = $sformatf("program %0d", p + 1);
      build_program(p);
      run_model();
      apply_reset();
      run_program();
    end
    $display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    report_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    $display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
design/proc_isa_pkg.sv
design/proc_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/commit_stage.sv
design/pipeline.sv
tests/pipeline_tb.sv
